/* src/sha256_pkg.sv */
// Shared word types, control structs and SHA-256 constants, imported by every core module
package sha256_pkg;

        typedef logic [31:0] word_t;            // Data word, schedule word, constant
        typedef logic [6:0]  round_t;           // Round count 0..64
        typedef logic [2:0]  read_idx_t;        // Digest word index

        localparam int BLOCK_WORDS  = 16;       // Message words per block
        localparam int ROUNDS       = 64;
        localparam int DIGEST_WORDS = 8;

        // Host command/status register, bit 3 down to bit 0
        typedef struct packed {
                logic busy;                     // Read only
                logic chain;                    // 1 continues the previous digest
                logic write;                    // Start a block
                logic read;                     // Start a digest read
        } cmd_t;

        // Eight working words, a in the top position
        typedef struct packed {
                word_t a;
                word_t b;
                word_t c;
                word_t d;
                word_t e;
                word_t f;
                word_t g;
                word_t h;
        } hash_state_t;

        // One-cycle strobes from the sequencer
        typedef struct packed {
                logic start;
                logic chain;
                logic absorb;                   // Rounds 1..15
                logic expand;                   // Rounds 16..63
                logic finish;                   // Round 64
        } round_ctl_t;

        typedef enum logic {ST_IDLE, ST_RUN} ctrl_state_t;

        // --------------------
        // Initial hash value and round constants
        localparam hash_state_t H_INIT = '{
                32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
                32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};

        localparam word_t K_TABLE [0:ROUNDS-1] = '{
                32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
                32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
                32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
                32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
                32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
                32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
                32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
                32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
                32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
                32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
                32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
                32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
                32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
                32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
                32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
                32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2};

endpackage

/* src/sha256_cmd_reg.sv */
// Host command/status register of the hash core, written by the host and read back as status
`timescale 1ns/100ps

module sha256_cmd_reg (
        input  logic                    clk_i,
        input  logic                    rst_i,
        input  logic [2:0]              cmd_i,          // Chain, W, R
        input  logic                    cmd_w_i,        // One-cycle write strobe
        input  logic                    busy_i,
        output sha256_pkg::cmd_t        cmd_o
);

        // --------------------
        // Bit 3  busy, mirrors the sequencer one edge late
        // Bit 2  chain, 0 first block, 1 chained block
        // Bit 1  W, start a block
        // Bit 0  R, start a digest read
        //
        // W and R act as level requests. The hardware clears them
        // as soon as the core is idle, so one write gives one request.

        always_ff @(posedge clk_i)
        begin
                if (rst_i)
                        cmd_o <= '0;
                else if (cmd_w_i)
                begin
                        // Busy bit is not writable
                        {cmd_o.chain, cmd_o.write, cmd_o.read} <= cmd_i;
                end
                else
                begin
                        cmd_o.busy <= busy_i;
                        if (!busy_i)
                        begin
                                cmd_o.write <= 1'b0;    // Auto clear
                                cmd_o.read  <= 1'b0;
                        end
                end
        end

endmodule

/* src/sha256_round_ctrl.sv */
// Round sequencer of the hash core: counts 64 rounds, issues step strobes and the round constant
`timescale 1ns/100ps

module sha256_round_ctrl (
        input  logic                    clk_i,
        input  logic                    rst_i,
        input  logic                    start_i,        // W bit of the command register
        input  logic                    chain_i,
        output sha256_pkg::round_ctl_t  ctl_o,
        output sha256_pkg::word_t       kt_o,
        output logic                    busy_o
);
        import sha256_pkg::*;

        ctrl_state_t    state;
        round_t         round;                  // 1..64 while running, 0 when idle
        logic           in_run;

        assign in_run = (state == ST_RUN);
        assign busy_o = in_run;

        // --------------------
        // Step strobes
        always_comb
        begin
                ctl_o.start  = !in_run && start_i;
                ctl_o.chain  = !in_run && start_i && chain_i;
                ctl_o.absorb = in_run && (round < BLOCK_WORDS);
                ctl_o.expand = in_run && (round >= BLOCK_WORDS) && (round < ROUNDS);
                ctl_o.finish = in_run && (round == ROUNDS);
        end

        always_ff @(posedge clk_i)
        begin
                if (rst_i)
                begin
                        state <= ST_IDLE;
                        round <= '0;
                end
                else
                begin
                        case (state)
                        ST_IDLE:
                                if (start_i)
                                begin
                                        state <= ST_RUN;
                                        round <= round_t'(1);
                                end
                        ST_RUN:
                                if (round == ROUNDS)
                                begin
                                        state <= ST_IDLE;       // Finish step done
                                        round <= '0;
                                end
                                else
                                        round <= round + 1'b1;
                        endcase
                end
        end

        // Constant for the step taken on the next edge
        always_ff @(posedge clk_i)
        begin
                if (rst_i)
                        kt_o <= '0;
                else if (round < ROUNDS)
                        kt_o <= K_TABLE[round[5:0]];
                else
                        kt_o <= '0;
        end

endmodule

/* src/sha256_msg_schedule.sv */
// Message schedule of the hash core that takes in the 16 block words and then expands W16 to W63
`timescale 1ns/100ps

module sha256_msg_schedule (
        input  logic                    clk_i,
        input  logic                    rst_i,
        input  sha256_pkg::word_t       text_i,
        input  sha256_pkg::round_ctl_t  ctl_i,
        output sha256_pkg::word_t       wt_o
);
        import sha256_pkg::*;

        // Window of the last 16 schedule words with W[t-1] on top
        word_t [BLOCK_WORDS-1:0] win;

        word_t  w_m2;                           // W[t-2]
        word_t  w_m15;                          // W[t-15]
        word_t  s0;
        word_t  s1;
        word_t  w_next;

        assign w_m2  = win[BLOCK_WORDS-2];
        assign w_m15 = win[1];

        // --------------------
        // Small sigma functions
        assign s0 = {w_m15[6:0], w_m15[31:7]} ^ {w_m15[17:0], w_m15[31:18]} ^ (w_m15 >> 3);
        assign s1 = {w_m2[16:0], w_m2[31:17]} ^ {w_m2[18:0], w_m2[31:19]} ^ (w_m2 >> 10);

        // W[t-7] and W[t-16] complete the sum
        assign w_next = s1 + win[BLOCK_WORDS-7] + s0 + win[0];

        always_ff @(posedge clk_i)
        begin
                if (rst_i)
                        win <= '0;
                else if (ctl_i.start || ctl_i.absorb)
                begin
                        win <= {text_i, win[BLOCK_WORDS-1:1]};  // Host word
                end
                else if (ctl_i.expand)
                begin
                        win <= {w_next, win[BLOCK_WORDS-1:1]};
                end
        end

        // Newest word feeds the round of the next edge
        assign wt_o = win[BLOCK_WORDS-1];

endmodule

/* src/sha256_compress.sv */
// Compression datapath of the hash core: working variables, round function and feed-forward add
`timescale 1ns/100ps

module sha256_compress (
        input  logic                    clk_i,
        input  logic                    rst_i,
        input  sha256_pkg::round_ctl_t  ctl_i,
        input  sha256_pkg::word_t       kt_i,
        input  sha256_pkg::word_t       wt_i,
        output sha256_pkg::hash_state_t digest_o
);
        import sha256_pkg::*;

        hash_state_t    work;                   // Working variables a..h
        hash_state_t    saved;                  // Hash value at block start
        hash_state_t    nxt;

        word_t  bsig0;
        word_t  bsig1;
        word_t  ch;
        word_t  maj;
        word_t  t1;
        word_t  t2;

        // --------------------
        // Round function
        assign bsig0 = {work.a[1:0], work.a[31:2]} ^ {work.a[12:0], work.a[31:13]}
                     ^ {work.a[21:0], work.a[31:22]};
        assign bsig1 = {work.e[5:0], work.e[31:6]} ^ {work.e[10:0], work.e[31:11]}
                     ^ {work.e[24:0], work.e[31:25]};

        assign ch  = (work.e & work.f) ^ (~work.e & work.g);
        assign maj = (work.a & work.b) ^ (work.a & work.c) ^ (work.b & work.c);

        assign t1 = work.h + bsig1 + ch + kt_i + wt_i;
        assign t2 = bsig0 + maj;

        always_comb
        begin
                nxt.a = t1 + t2;
                nxt.b = work.a;
                nxt.c = work.b;
                nxt.d = work.c;
                nxt.e = work.d + t1;
                nxt.f = work.e;
                nxt.g = work.f;
                nxt.h = work.g;
        end

        // --------------------
        // State update
        always_ff @(posedge clk_i)
        begin
                if (rst_i)
                begin
                        work  <= '0;
                        saved <= '0;
                end
                else if (ctl_i.start)
                begin
                        if (ctl_i.chain)
                                saved <= work;          // Continue from last digest
                        else
                        begin
                                work  <= H_INIT;
                                saved <= H_INIT;
                        end
                end
                else if (ctl_i.absorb || ctl_i.expand)
                        work <= nxt;
                else if (ctl_i.finish)
                begin
                        // Last round plus feed-forward
                        work.a <= nxt.a + saved.a;
                        work.b <= nxt.b + saved.b;
                        work.c <= nxt.c + saved.c;
                        work.d <= nxt.d + saved.d;
                        work.e <= nxt.e + saved.e;
                        work.f <= nxt.f + saved.f;
                        work.g <= nxt.g + saved.g;
                        work.h <= nxt.h + saved.h;
                end
        end

        assign digest_o = work;

endmodule

/* src/sha256_digest_read.sv */
// Digest read port of the hash core: shifts the 8 digest words out on text_o, word a first
`timescale 1ns/100ps

module sha256_digest_read (
        input  logic                    clk_i,
        input  logic                    rst_i,
        input  logic                    read_i,         // R bit of the command register
        input  logic                    busy_i,
        input  sha256_pkg::hash_state_t digest_i,
        output sha256_pkg::word_t       text_o
);
        import sha256_pkg::*;

        read_idx_t                      read_idx;
        word_t [DIGEST_WORDS-1:0]       words;          // Index 7 is word a

        assign words = digest_i;

        // --------------------
        // Count down from 7, then hold on word h
        always_ff @(posedge clk_i)
        begin
                if (rst_i)
                begin
                        read_idx <= '0;
                        text_o   <= '0;
                end
                else if (read_i)
                        read_idx <= read_idx_t'(DIGEST_WORDS - 1);
                else if (!busy_i)
                begin
                        text_o <= words[read_idx];
                        if (read_idx != '0)
                                read_idx <= read_idx - 1'b1;
                end
                else
                begin
                        // Digest is not valid mid-block
                        text_o <= '0;
                end
        end

endmodule

/* src/sha256_core.sv */
// Top level of the SHA-256 core: 32-bit word port plus a 4-bit command/status register
`timescale 1ns/100ps

module sha256_core (
        input  logic                    clk_i,
        input  logic                    rst_i,
        input  sha256_pkg::word_t       text_i,         // Message word in
        output sha256_pkg::word_t       text_o,         // Digest word out
        input  logic [2:0]              cmd_i,
        input  logic                    cmd_w_i,
        output logic [3:0]              cmd_o           // Busy, chain, W, R
);
        import sha256_pkg::*;

        cmd_t           cmd;
        round_ctl_t     ctl;
        word_t          kt;
        word_t          wt;
        hash_state_t    digest;
        logic           busy;

        assign cmd_o = cmd;

        sha256_cmd_reg u_cmd_reg (
                .clk_i          (clk_i),
                .rst_i          (rst_i),
                .cmd_i          (cmd_i),
                .cmd_w_i        (cmd_w_i),
                .busy_i         (busy),
                .cmd_o          (cmd)
        );

        sha256_round_ctrl u_round_ctrl (
                .clk_i          (clk_i),
                .rst_i          (rst_i),
                .start_i        (cmd.write),
                .chain_i        (cmd.chain),
                .ctl_o          (ctl),
                .kt_o           (kt),
                .busy_o         (busy)
        );

        sha256_msg_schedule u_msg_schedule (
                .clk_i          (clk_i),
                .rst_i          (rst_i),
                .text_i         (text_i),
                .ctl_i          (ctl),
                .wt_o           (wt)
        );

        sha256_compress u_compress (
                .clk_i          (clk_i),
                .rst_i          (rst_i),
                .ctl_i          (ctl),
                .kt_i           (kt),
                .wt_i           (wt),
                .digest_o       (digest)
        );

        sha256_digest_read u_digest_read (
                .clk_i          (clk_i),
                .rst_i          (rst_i),
                .read_i         (cmd.read),
                .busy_i         (busy),
                .digest_i       (digest),
                .text_o         (text_o)
        );

endmodule

/* testbench/tb_sha256_model.svh */
// Reference SHA-256 compression model and LCG random source, included inside the testbench module
`ifndef TB_SHA256_MODEL_SVH
`define TB_SHA256_MODEL_SVH

// Sixteen message words, word 0 in the top position
typedef logic [511:0] block_t;

// Next value of the linear congruential generator
function automatic word_t rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
endfunction

function automatic word_t rotr(input word_t x, input int n);
        return (x >> n) | (x << (32 - n));
endfunction

// --------------------
// One block of compression from the given hash value
function automatic hash_state_t model_compress(input hash_state_t h_in, input block_t blk);
        word_t          w [0:63];
        hash_state_t    v;
        hash_state_t    h_out;
        word_t          s0;
        word_t          s1;
        word_t          t1;
        word_t          t2;

        for (int t = 0; t < 16; t++)
                w[t] = blk[511 - 32*t -: 32];

        // Schedule expansion
        for (int t = 16; t < 64; t++)
        begin
                s0 = rotr(w[t-15], 7) ^ rotr(w[t-15], 18) ^ (w[t-15] >> 3);
                s1 = rotr(w[t-2], 17) ^ rotr(w[t-2], 19) ^ (w[t-2] >> 10);
                w[t] = w[t-16] + s0 + w[t-7] + s1;
        end

        v = h_in;
        for (int t = 0; t < 64; t++)
        begin
                s1 = rotr(v.e, 6) ^ rotr(v.e, 11) ^ rotr(v.e, 25);
                t1 = v.h + s1 + ((v.e & v.f) ^ (~v.e & v.g)) + K_TABLE[t] + w[t];
                s0 = rotr(v.a, 2) ^ rotr(v.a, 13) ^ rotr(v.a, 22);
                t2 = s0 + ((v.a & v.b) ^ (v.a & v.c) ^ (v.b & v.c));
                v = '{t1 + t2, v.a, v.b, v.c, v.d + t1, v.e, v.f, v.g};
        end

        // Feed-forward
        h_out.a = h_in.a + v.a;
        h_out.b = h_in.b + v.b;
        h_out.c = h_in.c + v.c;
        h_out.d = h_in.d + v.d;
        h_out.e = h_in.e + v.e;
        h_out.f = h_in.f + v.f;
        h_out.g = h_in.g + v.g;
        h_out.h = h_in.h + v.h;
        return h_out;
endfunction

`endif

/* testbench/tb_sha256.sv */
// Self-checking testbench of the SHA-256 core that is compiled with build.f and run with tb_sha256 as top
`timescale 1ns/100ps

module tb_sha256;
        import sha256_pkg::*;

        localparam int CLK_PERIOD    = 100;
        localparam int RESET_CYCLES  = 16;
        localparam int DRIVE_DELAY   = 10;
        localparam int MAX_BLOCKS    = 20;
        localparam int BLOCK_CYCLES  = 90;     // Write, rounds and read of one block
        localparam int RANDOM_BLOCKS = 15;

        logic           clk_i;
        logic           rst_i;
        word_t          text_i;
        word_t          text_o;
        logic [2:0]     cmd_i;
        logic           cmd_w_i;
        logic [3:0]     cmd_o;

        logic [31:0]    lcg_state;
        hash_state_t    model_state;            // Digest the DUT should hold

        `include "tb_sha256_model.svh"

        // --------------------
        // Known vectors
        localparam block_t ABC_BLOCK = {32'h61626380, {14{32'h0}}, 32'h00000018};
        localparam hash_state_t ABC_DIGEST = {
                32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
                32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad};
        localparam block_t LONG_BLOCK0 = {
                32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
                32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
                32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
                32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000};
        localparam block_t LONG_BLOCK1 = {{15{32'h0}}, 32'h000001c0};
        localparam hash_state_t LONG_DIGEST = {
                32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
                32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1};

        sha256_core u_sha256_core (
                .clk_i          (clk_i),
                .rst_i          (rst_i),
                .text_i         (text_i),
                .text_o         (text_o),
                .cmd_i          (cmd_i),
                .cmd_w_i        (cmd_w_i),
                .cmd_o          (cmd_o)
        );

        always #(CLK_PERIOD / 2) clk_i = ~clk_i;

        task check_value(input string name, input logic [255:0] expected,
                         input logic [255:0] actual);
                if (expected !== actual)
                begin
                        $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
                        $display("Result: FAILED");
                        $fatal(1, "Stopped at the first mismatch");
                end
        endtask

        task next_cycle();
                @(posedge clk_i);
                #DRIVE_DELAY;
        endtask

        task write_cmd(input logic [2:0] bits);
                cmd_i   = bits;
                cmd_w_i = 1'b1;
                next_cycle();
                cmd_w_i = 1'b0;
        endtask

        // Host word timing, busy window and model update for one block
        task run_block(input string name, input block_t blk, input logic chain);
                int cyc;
                write_cmd({chain, 2'b10});      // Edge C
                text_i = blk[511 -: 32];
                for (int n = 1; n < BLOCK_WORDS; n++)
                begin
                        next_cycle();
                        text_i = blk[511 - 32*n -: 32];
                        if (n == 2)
                        begin
                                check_value($sformatf("%s busy", name), 1, cmd_o[3]);
                                check_value($sformatf("%s chain", name), chain, cmd_o[2]);
                                check_value($sformatf("%s W clear", name), 0, cmd_o[1:0]);
                                check_value($sformatf("%s text_o busy", name), 0, text_o);
                        end
                end
                cyc = BLOCK_WORDS - 1;
                while (cmd_o[3] !== 1'b0)
                begin
                        next_cycle();
                        cyc++;
                end
                check_value($sformatf("%s busy fall", name), ROUNDS + 2, cyc);
                model_state = model_compress(chain ? model_state : H_INIT, blk);
        endtask

        task read_check(input string name, input hash_state_t expected);
                hash_state_t got;
                write_cmd(3'b001);              // Edge R
                check_value($sformatf("%s R set", name), 1, cmd_o[0]);
                next_cycle();
                check_value($sformatf("%s R clear", name), 0, cmd_o[0]);
                for (int i = 0; i < DIGEST_WORDS; i++)
                begin
                        next_cycle();
                        got[255 - 32*i -: 32] = text_o;        // Word a first
                end
                check_value(name, expected, got);
                repeat (2) next_cycle();
                check_value($sformatf("%s hold h", name), expected.h, text_o);
        endtask

        // --------------------
        // Watchdog
        initial
        begin
                #((MAX_BLOCKS * BLOCK_CYCLES + RESET_CYCLES) * CLK_PERIOD);
                $display("Timeout: the DUT did not finish the tests in time");
                $display("Result: FAILED");
                $fatal(1, "Watchdog expired");
        end

        initial
        begin
                block_t blk;
                word_t  r;

                clk_i       = 1'b0;
                rst_i       = 1'b1;
                text_i      = '0;
                cmd_i       = '0;
                cmd_w_i     = 1'b0;
                lcg_state   = 32'h0e6c51e0;
                model_state = H_INIT;
                repeat (RESET_CYCLES) @(posedge clk_i);
                #DRIVE_DELAY;
                rst_i = 1'b0;
                check_value("reset cmd_o", 0, cmd_o);
                check_value("reset text_o", 0, text_o);

                run_block("abc", ABC_BLOCK, 1'b0);
                check_value("abc model", ABC_DIGEST, model_state);
                read_check("abc digest", ABC_DIGEST);

                run_block("two block first", LONG_BLOCK0, 1'b0);
                run_block("two block second", LONG_BLOCK1, 1'b1);     // Chained
                check_value("two block model", LONG_DIGEST, model_state);
                read_check("two block digest", LONG_DIGEST);

                // --------------------
                // Random blocks with random chaining
                for (int n = 0; n < RANDOM_BLOCKS; n++)
                begin
                        for (int i = 0; i < BLOCK_WORDS; i++)
                                blk[511 - 32*i -: 32] = rand_word();
                        r = rand_word();
                        run_block($sformatf("random %0d", n), blk, r[16]);
                        read_check($sformatf("random %0d digest", n), model_state);
                end

                $display("Result: PASSED");
                $finish;
        end

endmodule

/* build.f */
src/sha256_pkg.sv
src/sha256_cmd_reg.sv
src/sha256_round_ctrl.sv
src/sha256_msg_schedule.sv
src/sha256_compress.sv
src/sha256_digest_read.sv
src/sha256_core.sv
+incdir+testbench
testbench/tb_sha256.sv
